// ==== cwb_pkg.sv ====
package cwb_pkg;

   // cache side
   localparam int ADDR_W     = 16;    // byte address
   localparam int DATA_W     = 32;    // cache word
   localparam int NBYTES     = 4;     // bytes per cache word
   localparam int NBYTES_W   = $clog2(NBYTES);

   // memory bus side
   localparam int BE_DATA_W  = 64;    // bus word
   localparam int BE_NBYTES  = 8;     // bytes per bus word
   localparam int BE_OFF_W   = $clog2(BE_NBYTES);  // byte offset in bus word

   // banking, bank bit sits just above the bus word offset
   localparam int N_BANKS    = 2;
   localparam int BANK_W     = 1;
   localparam int BANK_LSB   = 3;

   // write buffer
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   // statistics
   localparam int CNT_W      = 16;

   localparam logic [1:0] RESP_OKAY = 2'b00;  // axi OKAY

   // one write from the cache core
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [NBYTES-1:0] strb;
   } cwb_req_t;

   // AW phase payload
   typedef struct packed {
      logic [ADDR_W-1:0] addr;        // bus word aligned
   } cwb_aw_t;

   // W phase payload
   typedef struct packed {
      logic [BE_DATA_W-1:0] data;
      logic [BE_NBYTES-1:0] strb;
      logic                 last;     // single beat, follows wvalid
   } cwb_w_t;

   // B phase payload
   typedef struct packed {
      logic [1:0] resp;
   } cwb_b_t;

endpackage

// ==== cwb_write_buffer.sv ====
`timescale 1ns/1ps

module cwb_write_buffer (
   input  logic               clk_i,
   input  logic               reset,
   // cache core side
   input  logic               push_i,
   input  cwb_pkg::cwb_req_t  push_req_i,
   output logic               full_o,
   // dispatcher side
   input  logic               pop_i,
   output logic               head_valid_o,
   output cwb_pkg::cwb_req_t  head_o
);

   cwb_pkg::cwb_req_t                  mem [cwb_pkg::FIFO_DEPTH];  // payload only
   logic [cwb_pkg::FIFO_PTR_W-1:0]     wr_ptr;
   logic [cwb_pkg::FIFO_PTR_W-1:0]     rd_ptr;
   logic [cwb_pkg::FIFO_CNT_W-1:0]     count;

   assign full_o       = (count == cwb_pkg::FIFO_CNT_W'(cwb_pkg::FIFO_DEPTH));
   assign head_valid_o = (count != '0);
   assign head_o       = mem[rd_ptr];  // visible one cycle after push

   always_ff @(posedge clk_i) begin
      if (push_i) begin
         mem[wr_ptr] <= push_req_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= (wr_ptr == cwb_pkg::FIFO_PTR_W'(cwb_pkg::FIFO_DEPTH - 1)) ?
                      '0 : wr_ptr + 1'b1;
         end
         if (pop_i) begin
            rd_ptr <= (rd_ptr == cwb_pkg::FIFO_PTR_W'(cwb_pkg::FIFO_DEPTH - 1)) ?
                      '0 : rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // both or neither
         endcase
      end
   end

   // producer and consumer must respect full and empty
   a_no_push_full: assert property (
      @(posedge clk_i) disable iff (reset) !(push_i && full_o)
   );

   a_no_pop_empty: assert property (
      @(posedge clk_i) disable iff (reset) !(pop_i && !head_valid_o)
   );

endmodule

// ==== cwb_bank_dispatch.sv ====
`timescale 1ns/1ps

module cwb_bank_dispatch (
   // buffer head
   input  logic                        head_valid_i,
   input  cwb_pkg::cwb_req_t           head_i,
   output logic                        pop_o,
   // write channels
   output logic [cwb_pkg::N_BANKS-1:0] ch_valid_o,
   output cwb_pkg::cwb_req_t           ch_req_o,
   input  logic [cwb_pkg::N_BANKS-1:0] ch_ready_i
);

   logic [cwb_pkg::BANK_W-1:0] bank;  // target of the head request

   // bank select taken right above the bus word offset
   assign bank = head_i.addr[cwb_pkg::BANK_LSB +: cwb_pkg::BANK_W];

   // request payload is shared, only the valid is steered
   assign ch_req_o = head_i;

   always_comb begin
      for (int k = 0; k < cwb_pkg::N_BANKS; k++) begin
         ch_valid_o[k] = head_valid_i && (bank == cwb_pkg::BANK_W'(k));
      end
   end

   // head leaves the buffer only when its own channel takes it,
   // so a busy bank holds back every write queued behind it
   assign pop_o = head_valid_i && ch_ready_i[bank];

endmodule

// ==== cwb_write_channel.sv ====
`timescale 1ns/1ps

module cwb_write_channel (
   input  logic               clk_i,
   input  logic               reset,
   // from dispatcher
   input  logic               req_valid_i,
   input  cwb_pkg::cwb_req_t  req_i,
   output logic               req_ready_o,
   // AW phase
   output logic               awvalid_o,
   output cwb_pkg::cwb_aw_t   aw_o,
   input  logic               awready_i,
   // W phase
   output logic               wvalid_o,
   output cwb_pkg::cwb_w_t    w_o,
   input  logic               wready_i,
   // B phase
   input  logic               bvalid_i,
   input  cwb_pkg::cwb_b_t    b_i,
   output logic               bready_o,
   // to collector
   output logic               done_o,
   output logic               retry_o
);

   typedef enum logic [1:0] {
      IDLE    = 2'd0,
      ADDRESS = 2'd1,
      WRITE   = 2'd2,
      VERIFY  = 2'd3
   } state_t;

   state_t             state;
   cwb_pkg::cwb_req_t  req_q;    // write in flight, kept for retries
   logic               resp_ok;
   logic               resp_err;

   assign resp_ok  = (state == VERIFY) && bvalid_i && (b_i.resp == cwb_pkg::RESP_OKAY);
   assign resp_err = (state == VERIFY) && bvalid_i && (b_i.resp != cwb_pkg::RESP_OKAY);

   // free when idle, or when the current write completes
   assign req_ready_o = (state == IDLE) || resp_ok;

   assign awvalid_o = (state == ADDRESS);
   assign wvalid_o  = (state == WRITE);
   assign bready_o  = (state == VERIFY);
   assign done_o    = resp_ok;
   assign retry_o   = resp_err;

   // bus word aligned address
   assign aw_o.addr = {req_q.addr[cwb_pkg::ADDR_W-1:cwb_pkg::BE_OFF_W],
                       {cwb_pkg::BE_OFF_W{1'b0}}};

   // word replicated in every lane, strobes pick the right one
   assign w_o.data = {(cwb_pkg::BE_DATA_W / cwb_pkg::DATA_W){req_q.data}};
   assign w_o.strb = cwb_pkg::BE_NBYTES'(req_q.strb) <<
                     (cwb_pkg::NBYTES *
                      req_q.addr[cwb_pkg::NBYTES_W +: cwb_pkg::BE_OFF_W - cwb_pkg::NBYTES_W]);
   assign w_o.last = wvalid_o;  // single beat

   always_ff @(posedge clk_i) begin
      if (req_valid_i && req_ready_o) begin
         req_q <= req_i;
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (req_valid_i) state <= ADDRESS;
            end
            ADDRESS: begin
               if (awready_i) state <= WRITE;
            end
            WRITE: begin
               if (wready_i) state <= VERIFY;
            end
            default: begin  // VERIFY
               if (resp_ok) begin
                  state <= req_valid_i ? ADDRESS : IDLE;  // back to back writes
               end else if (resp_err) begin
                  state <= ADDRESS;  // resend same payload
               end
            end
         endcase
      end
   end

   a_aw_w_exclusive: assert property (
      @(posedge clk_i) disable iff (reset) !(awvalid_o && wvalid_o)
   );

   // payload held while the slave stalls
   a_aw_stable: assert property (
      @(posedge clk_i) disable iff (reset) awvalid_o && !awready_i |=> $stable(aw_o)
   );

   a_w_stable: assert property (
      @(posedge clk_i) disable iff (reset) wvalid_o && !wready_i |=> $stable(w_o)
   );

endmodule

// ==== cwb_resp_collect.sv ====
`timescale 1ns/1ps

module cwb_resp_collect (
   input  logic                        clk_i,
   input  logic                        reset,
   input  logic [cwb_pkg::N_BANKS-1:0] done_i,
   input  logic [cwb_pkg::N_BANKS-1:0] retry_i,
   input  logic [cwb_pkg::N_BANKS-1:0] busy_i,       // channel not idle
   input  logic                        buf_empty_i,
   output logic [cwb_pkg::CNT_W-1:0]   done_count_o,
   output logic [cwb_pkg::CNT_W-1:0]   retry_count_o,
   output logic                        idle_o
);

   logic [cwb_pkg::CNT_W-1:0] done_inc;
   logic [cwb_pkg::CNT_W-1:0] retry_inc;

   // several banks may finish in the same cycle
   always_comb begin
      done_inc  = '0;
      retry_inc = '0;
      for (int k = 0; k < cwb_pkg::N_BANKS; k++) begin
         done_inc  = done_inc  + cwb_pkg::CNT_W'(done_i[k]);
         retry_inc = retry_inc + cwb_pkg::CNT_W'(retry_i[k]);
      end
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         done_count_o  <= '0;
         retry_count_o <= '0;
         idle_o        <= 1'b1;
      end else begin
         done_count_o  <= done_count_o + done_inc;
         retry_count_o <= retry_count_o + retry_inc;
         idle_o        <= buf_empty_i && !(|busy_i);  // nothing queued or in flight
      end
   end

endmodule

// ==== cwb_top.sv ====
`timescale 1ns/1ps

module cwb_top (
   input  logic                                       clk_i,
   input  logic                                       reset,
   // cache core write port
   input  logic                                       req_valid_i,
   input  cwb_pkg::cwb_req_t                          req_i,
   output logic                                       req_ready_o,
   // per-bank memory write ports
   output logic             [cwb_pkg::N_BANKS-1:0]    m_awvalid_o,
   output cwb_pkg::cwb_aw_t [cwb_pkg::N_BANKS-1:0]    m_aw_o,
   input  logic             [cwb_pkg::N_BANKS-1:0]    m_awready_i,
   output logic             [cwb_pkg::N_BANKS-1:0]    m_wvalid_o,
   output cwb_pkg::cwb_w_t  [cwb_pkg::N_BANKS-1:0]    m_w_o,
   input  logic             [cwb_pkg::N_BANKS-1:0]    m_wready_i,
   input  logic             [cwb_pkg::N_BANKS-1:0]    m_bvalid_i,
   input  cwb_pkg::cwb_b_t  [cwb_pkg::N_BANKS-1:0]    m_b_i,
   output logic             [cwb_pkg::N_BANKS-1:0]    m_bready_o,
   // status
   output logic [cwb_pkg::CNT_W-1:0]                  done_count_o,
   output logic [cwb_pkg::CNT_W-1:0]                  retry_count_o,
   output logic                                       idle_o
);

   logic                         buf_full;
   logic                         push;
   logic                         head_valid;
   cwb_pkg::cwb_req_t            head;
   logic                         pop;
   logic [cwb_pkg::N_BANKS-1:0]  ch_valid;
   cwb_pkg::cwb_req_t            ch_req;
   logic [cwb_pkg::N_BANKS-1:0]  ch_ready;
   logic [cwb_pkg::N_BANKS-1:0]  ch_done;
   logic [cwb_pkg::N_BANKS-1:0]  ch_retry;
   logic [cwb_pkg::N_BANKS-1:0]  ch_busy;

   assign req_ready_o = !buf_full;
   assign push        = req_valid_i && !buf_full;
   assign ch_busy     = ~ch_ready;  // ready only in idle or on completion

   cwb_write_buffer u_buffer (
      .clk_i        (clk_i),
      .reset        (reset),
      .push_i       (push),
      .push_req_i   (req_i),
      .full_o       (buf_full),
      .pop_i        (pop),
      .head_valid_o (head_valid),
      .head_o       (head)
   );

   cwb_bank_dispatch u_dispatch (
      .head_valid_i (head_valid),
      .head_i       (head),
      .pop_o        (pop),
      .ch_valid_o   (ch_valid),
      .ch_req_o     (ch_req),
      .ch_ready_i   (ch_ready)
   );

   for (genvar k = 0; k < cwb_pkg::N_BANKS; k++) begin : g_chan
      cwb_write_channel u_chan (
         .clk_i       (clk_i),
         .reset       (reset),
         .req_valid_i (ch_valid[k]),
         .req_i       (ch_req),
         .req_ready_o (ch_ready[k]),
         .awvalid_o   (m_awvalid_o[k]),
         .aw_o        (m_aw_o[k]),
         .awready_i   (m_awready_i[k]),
         .wvalid_o    (m_wvalid_o[k]),
         .w_o         (m_w_o[k]),
         .wready_i    (m_wready_i[k]),
         .bvalid_i    (m_bvalid_i[k]),
         .b_i         (m_b_i[k]),
         .bready_o    (m_bready_o[k]),
         .done_o      (ch_done[k]),
         .retry_o     (ch_retry[k])
      );
   end

   cwb_resp_collect u_collect (
      .clk_i         (clk_i),
      .reset         (reset),
      .done_i        (ch_done),
      .retry_i       (ch_retry),
      .busy_i        (ch_busy),
      .buf_empty_i   (!head_valid),
      .done_count_o  (done_count_o),
      .retry_count_o (retry_count_o),
      .idle_o        (idle_o)
   );

   // dispatcher steers each head to a single bank
   a_one_bank: assert property (
      @(posedge clk_i) disable iff (reset) $onehot0(ch_valid)
   );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   initial clk_o = 1'b0;
   always #10 clk_o = ~clk_o;  // 20 ns period

   initial begin
      reset_o = 1'b1;
      repeat (16) @(posedge clk_o);
      reset_o <= 1'b0;
   end

endmodule

// ==== tb_cwb.sv ====
`timescale 1ns/1ps

module tb_cwb;

   localparam int MAX_LINES = 64;
   localparam int N = cwb_pkg::N_BANKS;

   logic clk;
   logic reset;
   logic req_valid;
   cwb_pkg::cwb_req_t req;
   logic req_ready;
   logic [N-1:0] m_awvalid;
   cwb_pkg::cwb_aw_t [N-1:0] m_aw;
   logic [N-1:0] awready = '0;
   logic [N-1:0] m_wvalid;
   cwb_pkg::cwb_w_t [N-1:0] m_w;
   logic [N-1:0] wready = '0;
   logic [N-1:0] bvalid = '0;
   cwb_pkg::cwb_b_t [N-1:0] m_b = '0;
   logic [N-1:0] m_bready;
   logic [cwb_pkg::CNT_W-1:0] done_count;
   logic [cwb_pkg::CNT_W-1:0] retry_count;
   logic idle;

   // trace contents and what the model expects per bank
   cwb_pkg::cwb_req_t trace_req [MAX_LINES];
   logic trace_err [MAX_LINES];
   int beats [MAX_LINES];              // W beats seen per write
   int bank_idx [N][MAX_LINES];
   int bank_len [N];
   int bank_pos [N];
   int n_lines;
   int n_err;
   logic [7:0] ref_mem [int];          // built from the trace alone
   logic [7:0] mem_model [int];        // written by the bank models
   logic [15:0] aw_seen [N];
   logic [N-1:0] retry_pend = '0;
   int pushed;
   int started;                        // first AW handshake of each write
   int seed = 32'he2d8_a5d4;

   tb_clock_gen u_clock_gen (.clk_o(clk), .reset_o(reset));

   cwb_top u_cwb_top (
      .clk_i(clk), .reset(reset),
      .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
      .m_awvalid_o(m_awvalid), .m_aw_o(m_aw), .m_awready_i(awready),
      .m_wvalid_o(m_wvalid), .m_w_o(m_w), .m_wready_i(wready),
      .m_bvalid_i(bvalid), .m_b_i(m_b), .m_bready_o(m_bready),
      .done_count_o(done_count), .retry_count_o(retry_count), .idle_o(idle)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         fail_run($sformatf("FAIL %s: expected %0h, actual %0h", name, expected, actual));
      end
   endtask

   task automatic load_trace();
      int fd;
      int got;
      int cnt;
      int i;
      int b;
      string line;
      logic [15:0] a;
      logic [31:0] d;
      logic [3:0] s;
      logic e;
      cnt = -1;  // count line not read yet
      i = 0;
      fd = $fopen("cwb_trace.txt", "r");
      if (fd == 0) fail_run("could not open cwb_trace.txt");
      while (!$feof(fd) && (cnt < 0 || i < cnt)) begin
         got = $fgets(line, fd);
         if (got == 0 || line.len() < 2 || line.getc(0) == "#") continue;
         if (cnt < 0) begin
            got = $sscanf(line, "%d", cnt);
            if (got != 1 || cnt < 1 || cnt > MAX_LINES) fail_run("bad count line in trace");
         end else begin
            got = $sscanf(line, "%h %h %h %h", a, d, s, e);
            if (got != 4) fail_run("malformed line in trace");
            trace_req[i] = '{addr: a, data: d, strb: s};
            trace_err[i] = e;
            n_err += int'(e);
            b = int'(a[cwb_pkg::BANK_LSB]);
            bank_idx[b][bank_len[b]] = i;
            bank_len[b]++;
            for (int j = 0; j < cwb_pkg::NBYTES; j++) begin
               if (s[j]) ref_mem[int'({a[15:2], 2'b00}) + j] = d[8*j +: 8];
            end
            i++;
         end
      end
      $fclose(fd);
      if (cnt < 0 || i != cnt) fail_run("trace has fewer writes than its count line");
      n_lines = cnt;
   endtask

   task automatic check_quiet(input string when);
      check_value({when, " awvalid"}, 64'(0), 64'(m_awvalid));
      check_value({when, " wvalid"}, 64'(0), 64'(m_wvalid));
      check_value({when, " bready"}, 64'(0), 64'(m_bready));
      check_value({when, " idle"}, 64'(1), 64'(idle));
      check_value({when, " req_ready"}, 64'(1), 64'(req_ready));
   endtask

   // bank memory models with random stalls and the monitors
   always @(posedge clk) begin : bank_models
      int idx;
      int r;
      logic [1:0] resp;
      logic [7:0] exp_strb;
      cwb_pkg::cwb_req_t wr;
      string tag;
      if (!reset && !req_ready && (pushed - started < cwb_pkg::FIFO_DEPTH)) begin
         fail_run("req_ready dropped with fewer than FIFO_DEPTH writes outstanding");
      end
      if (!reset && req_valid && req_ready) pushed++;
      for (int k = 0; k < N; k++) begin
         if (m_awvalid[k] && awready[k]) begin
            if (!retry_pend[k]) started++;
            retry_pend[k] = 1'b0;
            aw_seen[k] = m_aw[k].addr;
         end
         if (m_wvalid[k] && wready[k]) begin
            if (bank_pos[k] >= bank_len[k]) begin
               fail_run($sformatf("bank %0d got a W beat with no write left for it", k));
            end
            idx = bank_idx[k][bank_pos[k]];
            wr = trace_req[idx];
            tag = $sformatf("bank%0d write%0d", k, idx);
            exp_strb = wr.addr[2] ? {wr.strb, 4'b0000} : {4'b0000, wr.strb};
            check_value({tag, " bank bit"}, 64'(k), 64'(aw_seen[k][cwb_pkg::BANK_LSB]));
            check_value({tag, " aw addr"}, 64'({wr.addr[15:3], 3'b000}), 64'(aw_seen[k]));
            check_value({tag, " w strb"}, 64'(exp_strb), 64'(m_w[k].strb));
            check_value({tag, " w data"}, {wr.data, wr.data}, m_w[k].data);
            check_value({tag, " w last"}, 64'(1), 64'(m_w[k].last));
            beats[idx]++;
            if (trace_err[idx] && beats[idx] == 1) begin
               resp = 2'b10;  // slave error on the first attempt only
               retry_pend[k] = 1'b1;
            end else begin
               resp = cwb_pkg::RESP_OKAY;
               for (int j = 0; j < cwb_pkg::BE_NBYTES; j++) begin
                  if (m_w[k].strb[j]) mem_model[int'(aw_seen[k]) + j] = m_w[k].data[8*j +: 8];
               end
               bank_pos[k]++;
            end
            bvalid[k] <= 1'b1;
            m_b[k].resp <= resp;
         end else if (bvalid[k] && m_bready[k]) begin
            bvalid[k] <= 1'b0;
         end
         r = $random(seed);
         awready[k] <= r[0];
         wready[k] <= r[1];
      end
   end

   initial begin : watchdog
      wait (n_lines > 0);
      repeat (n_lines * 40 + 100) @(posedge clk);
      fail_run("watchdog expired before the writes drained");
   end

   initial begin : stimulus
      int idx;
      req_valid = 1'b0;
      req = '0;
      load_trace();
      @(posedge clk);
      while (reset) begin
         check_quiet("in reset");
         @(posedge clk);
      end
      repeat (2) begin
         check_quiet("after reset");
         @(posedge clk);
      end
      idx = 0;
      while (idx < n_lines) begin
         req_valid <= 1'b1;
         req <= trace_req[idx];
         @(posedge clk);
         if (req_ready) idx++;  // taken on this edge
      end
      req_valid <= 1'b0;
      repeat (2) @(posedge clk);
      while (!idle) @(posedge clk);
      check_value("done count", 64'(n_lines), 64'(done_count));
      check_value("retry count", 64'(n_err), 64'(retry_count));
      for (int i = 0; i < n_lines; i++) begin
         check_value($sformatf("write%0d beats", i), 64'(1 + int'(trace_err[i])), 64'(beats[i]));
      end
      check_value("memory bytes written", 64'(ref_mem.num()), 64'(mem_model.num()));
      foreach (ref_mem[a]) begin
         if (!mem_model.exists(a)) fail_run($sformatf("byte %0h never written to memory", a));
         check_value($sformatf("memory byte %0h", a), 64'(ref_mem[a]), 64'(mem_model[a]));
      end
      $display("Test passed");
      $finish;
   end

endmodule

// ==== cwb_trace.txt ====
# columns: address data strobes error-inject, all hex
# first data line is the number of writes that follow
16
0000 11223344 f 0
0004 55667788 f 0
0008 99aabbcc f 1
000c ddeeff00 3 0
0010 a5a5a5a5 1 0
0018 5a5a5a5a 8 1
0014 01020304 6 0
001c 0badf00d f 0
0100 cafe0001 f 0
0108 cafe0002 f 0
0100 beef0003 c 1
010c 12345678 5 0
0204 87654321 a 0
020c fedcba98 f 1
0000 ffff0000 4 0
0208 00c0ffee 2 0

// ==== sources.f ====
cwb_pkg.sv
cwb_write_buffer.sv
cwb_bank_dispatch.sv
cwb_write_channel.sv
cwb_resp_collect.sv
cwb_top.sv
tb_clock_gen.sv
tb_cwb.sv

// ==== Makefile ====
TOP = tb_cwb

.PHONY: run build lint clean

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir
